/* Bender.yml */
package:
  name: dcache

sources:
  - cache_pkg.sv
  - axi_pkg.sv
  - cache_ctrl.sv
  - cache_store.sv
  - line_fill.sv
  - line_evict.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_axi_mem.sv
      - tb_dcache.sv

/* axi_pkg.sv */
package axi_pkg;

    // Burst type for a linear walk through the line
    localparam logic [1:0] burst_incr = 2'b01;

    // Every beat carries one 8-byte word
    localparam logic [2:0] beat_size = 3'b011;

    localparam logic [1:0] resp_okay = 2'b00; // Normal access success

endpackage

/* cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl import cache_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  req_valid,
    input  logic  req_write,
    input  addr_t req_addr,
    input  word_t req_wdata,
    input  strb_t req_wstrb,
    output logic  req_ready,
    output logic  rsp_valid,
    output word_t rsp_rdata,
    input  logic  rsp_ready,
    input  logic  lookup_hit,
    input  word_t hit_rdata,
    input  logic  victim_dirty,
    input  logic  fill_done,
    input  logic  evict_done,
    output addr_t cur_addr,
    output logic  cur_write,
    output word_t cur_wdata,
    output strb_t cur_wstrb,
    output logic  word_write,
    output logic  install,
    output logic  fill_start,
    output logic  evict_start
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_respond,
        st_evict,
        st_fill,
        st_install
    } state_t;

    state_t state;
    state_t state_next;

    assign req_ready = (state == st_idle); // One request in flight at most

    always_comb begin
        state_next  = state;
        word_write  = 1'b0;
        install     = 1'b0;
        fill_start  = 1'b0;
        evict_start = 1'b0;
        case (state)
            st_idle: begin
                if (req_valid) begin
                    state_next = st_lookup;
                end
            end
            st_lookup: begin
                if (lookup_hit) begin
                    word_write = cur_write; // Merge lands with the response edge
                    state_next = st_respond;
                end else if (victim_dirty) begin
                    evict_start = 1'b1;
                    state_next  = st_evict;
                end else begin
                    fill_start = 1'b1;
                    state_next = st_fill;
                end
            end
            st_respond: begin
                if (rsp_ready) begin
                    state_next = st_idle;
                end
            end
            st_evict: begin
                if (evict_done) begin
                    fill_start = 1'b1; // Refill right behind the write-back
                    state_next = st_fill;
                end
            end
            st_fill: begin
                if (fill_done) begin
                    state_next = st_install;
                end
            end
            st_install: begin
                install    = 1'b1;
                state_next = st_lookup; // Retry now hits
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= st_idle;
            rsp_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (state == st_lookup && lookup_hit) begin
                rsp_valid <= 1'b1;
            end else if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // Request and response payload
    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            cur_addr  <= req_addr;
            cur_write <= req_write;
            cur_wdata <= req_wdata;
            cur_wstrb <= req_wstrb;
        end
        if (state == st_lookup && lookup_hit) begin
            rsp_rdata <= hit_rdata;
        end
    end

    // Response is held unchanged under core back-pressure
    rsp_hold: assert property (@(posedge clock) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

endmodule

/* cache_pkg.sv */
package cache_pkg;

    // Core-side bus widths
    localparam int addr_width = 32;
    localparam int word_width = 64;
    localparam int strb_width = word_width / 8;

    typedef logic [addr_width-1:0] addr_t; // Byte address
    typedef logic [word_width-1:0] word_t; // Full data word
    typedef logic [strb_width-1:0] strb_t; // One bit per byte lane

    // Default geometry, picked up by the top level
    localparam int default_sets       = 4;
    localparam int default_ways       = 2;
    localparam int default_line_words = 8;

endpackage

/* cache_store.sv */
`timescale 1ns/10ps

module cache_store import cache_pkg::*; #(
    parameter int num_sets   = default_sets,
    parameter int num_ways   = default_ways,
    parameter int line_words = default_line_words
) (
    input  logic                             clock,
    input  logic                             reset,
    input  addr_t                            cur_addr,
    input  logic                             cur_write,
    input  word_t                            cur_wdata,
    input  strb_t                            cur_wstrb,
    input  logic                             word_write,
    input  logic                             install,
    input  logic [line_words*word_width-1:0] fill_line,
    output logic                             lookup_hit,
    output word_t                            hit_rdata,
    output logic                             victim_dirty,
    output addr_t                            victim_addr,
    output logic [line_words*word_width-1:0] victim_line
);

    localparam int offset_bits = $clog2(line_words) + 3;
    localparam int index_bits  = $clog2(num_sets);
    localparam int set_bits    = (index_bits > 0) ? index_bits : 1;
    localparam int tag_bits    = addr_width - offset_bits - index_bits;
    localparam int way_bits    = (num_ways > 1) ? $clog2(num_ways) : 1;
    localparam int word_bits   = (line_words > 1) ? $clog2(line_words) : 1;

    logic [tag_bits-1:0] tag_mem  [num_sets][num_ways];
    word_t               data_mem [num_sets][num_ways][line_words];
    logic [num_ways-1:0] valid_q  [num_sets];
    logic [num_ways-1:0] dirty_q  [num_sets];
    logic [way_bits-1:0] rr_count;

    logic [set_bits-1:0]  set_sel;
    logic [word_bits-1:0] word_sel;
    logic [tag_bits-1:0]  cur_tag;
    logic [way_bits-1:0]  hit_way;
    logic [way_bits-1:0]  victim_way;
    word_t                old_word;
    word_t                merged;

    // Address split into tag, set, word and byte
    assign set_sel  = set_bits'((cur_addr >> offset_bits) % num_sets);
    assign word_sel = word_bits'((cur_addr >> 3) % line_words);
    assign cur_tag  = tag_bits'(cur_addr >> (offset_bits + index_bits));

    always_comb begin
        lookup_hit = 1'b0;
        hit_way    = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (valid_q[set_sel][w] && tag_mem[set_sel][w] == cur_tag) begin
                lookup_hit = 1'b1;
                hit_way    = way_bits'(w);
            end
        end
    end

    // Lowest invalid way first and the round robin otherwise
    always_comb begin
        victim_way = rr_count;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_q[set_sel][w]) begin
                victim_way = way_bits'(w);
            end
        end
    end

    assign old_word = data_mem[set_sel][hit_way][word_sel];

    always_comb begin
        merged = old_word;
        for (int b = 0; b < strb_width; b++) begin
            if (cur_wstrb[b]) begin
                merged[8*b +: 8] = cur_wdata[8*b +: 8];
            end
        end
    end

    assign hit_rdata    = cur_write ? merged : old_word;
    assign victim_dirty = valid_q[set_sel][victim_way] && dirty_q[set_sel][victim_way];
    assign victim_addr  = (addr_t'(tag_mem[set_sel][victim_way]) << (offset_bits + index_bits))
                        | (addr_t'(set_sel) << offset_bits);

    always_comb begin
        for (int i = 0; i < line_words; i++) begin
            victim_line[i*word_width +: word_width] = data_mem[set_sel][victim_way][i];
        end
    end

    always_ff @(posedge clock) begin
        if (word_write) begin
            data_mem[set_sel][hit_way][word_sel] <= merged;
        end
        if (install) begin
            tag_mem[set_sel][victim_way] <= cur_tag;
            for (int i = 0; i < line_words; i++) begin
                data_mem[set_sel][victim_way][i] <= fill_line[i*word_width +: word_width];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            rr_count <= '0;
        end else begin
            if (word_write) begin
                dirty_q[set_sel][hit_way] <= 1'b1;
            end
            if (install) begin
                valid_q[set_sel][victim_way] <= 1'b1;
                dirty_q[set_sel][victim_way] <= 1'b0; // Fresh line matches memory
                rr_count <= (rr_count == way_bits'(num_ways - 1)) ? '0 : rr_count + 1'b1;
            end
        end
    end

    // Controller only installs after a real miss
    no_install_on_hit: assert property (@(posedge clock) disable iff (reset)
        install |-> !lookup_hit);

endmodule

/* dcache_top.sv */
`timescale 1ns/10ps

module dcache_top import cache_pkg::*; #(
    parameter int num_sets   = default_sets,
    parameter int num_ways   = default_ways,
    parameter int line_words = default_line_words
) (
    input  logic        clock,
    input  logic        reset,

    // Core request
    input  logic        req_valid,
    input  logic        req_write,
    input  addr_t       req_addr,
    input  word_t       req_wdata,
    input  strb_t       req_wstrb,
    output logic        req_ready,

    // Core response
    output logic        rsp_valid,
    output word_t       rsp_rdata,
    input  logic        rsp_ready,

    // AXI read address
    output logic        axi_arvalid,
    output addr_t       axi_araddr,
    output logic [7:0]  axi_arlen,
    output logic [2:0]  axi_arsize,
    output logic [1:0]  axi_arburst,
    input  logic        axi_arready,

    // AXI read data
    input  logic        axi_rvalid,
    input  word_t       axi_rdata,
    input  logic        axi_rlast,
    output logic        axi_rready,

    // AXI write address
    output logic        axi_awvalid,
    output addr_t       axi_awaddr,
    output logic [7:0]  axi_awlen,
    output logic [2:0]  axi_awsize,
    output logic [1:0]  axi_awburst,
    input  logic        axi_awready,

    // AXI write data
    output logic        axi_wvalid,
    output word_t       axi_wdata,
    output strb_t       axi_wstrb,
    output logic        axi_wlast,
    input  logic        axi_wready,

    // AXI write response
    input  logic        axi_bvalid,
    input  logic [1:0]  axi_bresp,
    output logic        axi_bready
);

    localparam int line_width = line_words * word_width;

    addr_t                  cur_addr;
    logic                   cur_write;
    word_t                  cur_wdata;
    strb_t                  cur_wstrb;
    logic                   word_write;
    logic                   install;
    logic                   fill_start;
    logic                   fill_done;
    logic                   evict_start;
    logic                   evict_done;
    logic                   lookup_hit;
    word_t                  hit_rdata;
    logic                   victim_dirty;
    addr_t                  victim_addr;
    logic [line_width-1:0]  victim_line;
    logic [line_width-1:0]  fill_line;

    cache_ctrl u_ctrl (
        .clock        (clock),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_wstrb    (req_wstrb),
        .req_ready    (req_ready),
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .rsp_ready    (rsp_ready),
        .lookup_hit   (lookup_hit),
        .hit_rdata    (hit_rdata),
        .victim_dirty (victim_dirty),
        .fill_done    (fill_done),
        .evict_done   (evict_done),
        .cur_addr     (cur_addr),
        .cur_write    (cur_write),
        .cur_wdata    (cur_wdata),
        .cur_wstrb    (cur_wstrb),
        .word_write   (word_write),
        .install      (install),
        .fill_start   (fill_start),
        .evict_start  (evict_start)
    );

    cache_store #(
        .num_sets   (num_sets),
        .num_ways   (num_ways),
        .line_words (line_words)
    ) u_store (
        .clock        (clock),
        .reset        (reset),
        .cur_addr     (cur_addr),
        .cur_write    (cur_write),
        .cur_wdata    (cur_wdata),
        .cur_wstrb    (cur_wstrb),
        .word_write   (word_write),
        .install      (install),
        .fill_line    (fill_line),
        .lookup_hit   (lookup_hit),
        .hit_rdata    (hit_rdata),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line)
    );

    line_fill #(
        .line_words (line_words)
    ) u_fill (
        .clock       (clock),
        .reset       (reset),
        .fill_start  (fill_start),
        .cur_addr    (cur_addr),
        .axi_arvalid (axi_arvalid),
        .axi_araddr  (axi_araddr),
        .axi_arlen   (axi_arlen),
        .axi_arsize  (axi_arsize),
        .axi_arburst (axi_arburst),
        .axi_arready (axi_arready),
        .axi_rvalid  (axi_rvalid),
        .axi_rdata   (axi_rdata),
        .axi_rlast   (axi_rlast),
        .axi_rready  (axi_rready),
        .fill_line   (fill_line),
        .fill_done   (fill_done)
    );

    line_evict #(
        .line_words (line_words)
    ) u_evict (
        .clock       (clock),
        .reset       (reset),
        .evict_start (evict_start),
        .victim_addr (victim_addr),
        .victim_line (victim_line),
        .axi_awvalid (axi_awvalid),
        .axi_awaddr  (axi_awaddr),
        .axi_awlen   (axi_awlen),
        .axi_awsize  (axi_awsize),
        .axi_awburst (axi_awburst),
        .axi_awready (axi_awready),
        .axi_wvalid  (axi_wvalid),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wlast   (axi_wlast),
        .axi_wready  (axi_wready),
        .axi_bvalid  (axi_bvalid),
        .axi_bresp   (axi_bresp),
        .axi_bready  (axi_bready),
        .evict_done  (evict_done)
    );

endmodule

/* filelist.f */
cache_pkg.sv
axi_pkg.sv
cache_ctrl.sv
cache_store.sv
line_fill.sv
line_evict.sv
dcache_top.sv
tb_axi_mem.sv
tb_dcache.sv

/* line_evict.sv */
`timescale 1ns/10ps

module line_evict import cache_pkg::*, axi_pkg::*; #(
    parameter int line_words = default_line_words
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             evict_start,
    input  addr_t                            victim_addr,
    input  logic [line_words*word_width-1:0] victim_line,
    output logic                             axi_awvalid,
    output addr_t                            axi_awaddr,
    output logic [7:0]                       axi_awlen,
    output logic [2:0]                       axi_awsize,
    output logic [1:0]                       axi_awburst,
    input  logic                             axi_awready,
    output logic                             axi_wvalid,
    output word_t                            axi_wdata,
    output strb_t                            axi_wstrb,
    output logic                             axi_wlast,
    input  logic                             axi_wready,
    input  logic                             axi_bvalid,
    input  logic [1:0]                       axi_bresp,
    output logic                             axi_bready,
    output logic                             evict_done
);

    logic [8:0] beat;

    assign axi_awlen   = 8'(line_words - 1);
    assign axi_awsize  = beat_size;
    assign axi_awburst = burst_incr;
    assign axi_wstrb   = '1; // Whole line goes back
    assign axi_wdata   = victim_line[beat*word_width +: word_width];
    assign axi_wlast   = (beat == 9'(line_words - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            axi_awvalid <= 1'b0;
            axi_wvalid  <= 1'b0;
            axi_bready  <= 1'b0;
            evict_done  <= 1'b0;
            beat        <= '0;
        end else begin
            evict_done <= axi_bvalid && axi_bready;
            if (evict_start) begin
                axi_awvalid <= 1'b1;
                axi_wvalid  <= 1'b1;
                beat        <= '0;
            end else begin
                if (axi_awvalid && axi_awready) begin
                    axi_awvalid <= 1'b0;
                end
                if (axi_wvalid && axi_wready) begin
                    if (axi_wlast) begin
                        axi_wvalid <= 1'b0;
                        axi_bready <= 1'b1; // Now wait for the write response
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                if (axi_bvalid && axi_bready) begin
                    axi_bready <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (evict_start) begin
            axi_awaddr <= victim_addr;
        end
    end

    bresp_okay: assert property (@(posedge clock) disable iff (reset)
        axi_bvalid && axi_bready |-> axi_bresp == resp_okay);

endmodule

/* line_fill.sv */
`timescale 1ns/10ps

module line_fill import cache_pkg::*, axi_pkg::*; #(
    parameter int line_words = default_line_words
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             fill_start,
    input  addr_t                            cur_addr,
    output logic                             axi_arvalid,
    output addr_t                            axi_araddr,
    output logic [7:0]                       axi_arlen,
    output logic [2:0]                       axi_arsize,
    output logic [1:0]                       axi_arburst,
    input  logic                             axi_arready,
    input  logic                             axi_rvalid,
    input  word_t                            axi_rdata,
    input  logic                             axi_rlast,
    output logic                             axi_rready,
    output logic [line_words*word_width-1:0] fill_line,
    output logic                             fill_done
);

    logic [8:0] beat; // Up to 256 beats

    assign axi_arlen   = 8'(line_words - 1);
    assign axi_arsize  = beat_size;
    assign axi_arburst = burst_incr;

    always_ff @(posedge clock) begin
        if (reset) begin
            axi_arvalid <= 1'b0;
            axi_rready  <= 1'b0;
            fill_done   <= 1'b0;
            beat        <= '0;
        end else begin
            fill_done <= axi_rvalid && axi_rready && axi_rlast;
            if (fill_start) begin
                axi_arvalid <= 1'b1;
                axi_rready  <= 1'b1; // Data cannot precede the address anyway
                beat        <= '0;
            end else if (axi_arvalid && axi_arready) begin
                axi_arvalid <= 1'b0;
            end
            if (axi_rvalid && axi_rready) begin
                beat <= beat + 1'b1;
                if (axi_rlast) begin
                    axi_rready <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill_start) begin
            axi_araddr <= cur_addr & ~addr_t'(line_words * 8 - 1); // Line aligned
        end
        if (axi_rvalid && axi_rready) begin
            fill_line[beat*word_width +: word_width] <= axi_rdata;
        end
    end

    // Memory closes the burst on the expected beat
    rlast_on_last_beat: assert property (@(posedge clock) disable iff (reset)
        axi_rvalid && axi_rready |-> (axi_rlast == (beat == 9'(line_words - 1))));

endmodule

/* tb_axi_mem.sv */
`timescale 1ns/10ps

module tb_axi_mem import cache_pkg::*, axi_pkg::*; #(
    parameter int line_words = default_line_words
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       axi_arvalid,
    input  addr_t      axi_araddr,
    input  logic [7:0] axi_arlen,
    input  logic [2:0] axi_arsize,
    input  logic [1:0] axi_arburst,
    output logic       axi_arready,
    output logic       axi_rvalid,
    output word_t      axi_rdata,
    output logic       axi_rlast,
    input  logic       axi_rready,
    input  logic       axi_awvalid,
    input  addr_t      axi_awaddr,
    input  logic [7:0] axi_awlen,
    input  logic [2:0] axi_awsize,
    input  logic [1:0] axi_awburst,
    output logic       axi_awready,
    input  logic       axi_wvalid,
    input  word_t      axi_wdata,
    input  strb_t      axi_wstrb,
    input  logic       axi_wlast,
    output logic       axi_wready,
    output logic       axi_bvalid,
    output logic [1:0] axi_bresp,
    input  logic       axi_bready,
    output int         errors
);

    word_t      mem [addr_t]; // Only written words are stored
    logic       r_busy;
    logic       w_busy;
    addr_t      r_base;
    addr_t      w_base;
    logic [7:0] r_len;
    logic [8:0] r_beat;
    logic [8:0] w_beat;

    assign axi_bresp = resp_okay;

    initial begin
        axi_arready = 1'b0;
        axi_rvalid  = 1'b0;
        axi_rdata   = '0;
        axi_rlast   = 1'b0;
        axi_awready = 1'b0;
        axi_wready  = 1'b0;
        axi_bvalid  = 1'b0;
        errors      = 0;
    end

    // Untouched words read back as address XOR 5A5A_0000 in both halves
    function automatic word_t read_word(addr_t a);
        return mem.exists(a) ? mem[a] : {a ^ 32'h5A5A_0000, a ^ 32'h5A5A_0000};
    endfunction

    task automatic store_beat(input addr_t a, input word_t d, input strb_t s);
        word_t w;
        w = read_word(a);
        for (int b = 0; b < strb_width; b++) begin
            if (s[b]) begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        mem[a] = w;
    endtask

    // Read side serves one burst at a time with random gaps between beats
    always @(posedge clock) begin
        if (reset) begin
            axi_arready <= 1'b0;
            axi_rvalid  <= 1'b0;
            axi_rlast   <= 1'b0;
            r_busy      <= 1'b0;
            r_beat      <= '0;
        end else if (!r_busy) begin
            if (axi_arvalid && axi_arready) begin
                axi_arready <= 1'b0;
                r_busy      <= 1'b1;
                r_base      <= axi_araddr;
                r_len       <= axi_arlen;
                r_beat      <= '0;
            end else begin
                axi_arready <= 1'($urandom_range(0, 1));
            end
        end else if (axi_rvalid && axi_rready) begin
            axi_rvalid <= 1'b0;
            r_beat     <= r_beat + 1'b1;
            if (axi_rlast) begin
                r_busy <= 1'b0;
            end
        end else if (!axi_rvalid && $urandom_range(0, 3) != 0) begin
            axi_rvalid <= 1'b1;
            axi_rdata  <= read_word(r_base + addr_t'(8 * r_beat));
            axi_rlast  <= (r_beat == 9'(r_len));
        end
    end

    // Write side takes the address first, then the data beats and then the response
    always @(posedge clock) begin
        if (reset) begin
            axi_awready <= 1'b0;
            axi_wready  <= 1'b0;
            axi_bvalid  <= 1'b0;
            w_busy      <= 1'b0;
            w_beat      <= '0;
        end else if (!w_busy) begin
            if (axi_awvalid && axi_awready) begin
                axi_awready <= 1'b0;
                w_busy      <= 1'b1;
                w_base      <= axi_awaddr;
                w_beat      <= '0;
            end else begin
                axi_awready <= 1'($urandom_range(0, 1));
            end
        end else if (axi_bvalid) begin
            if (axi_bready) begin
                axi_bvalid <= 1'b0;
                w_busy     <= 1'b0;
            end
        end else if (axi_wvalid && axi_wready) begin
            store_beat(w_base + addr_t'(8 * w_beat), axi_wdata, axi_wstrb);
            axi_wready <= 1'b0;
            w_beat     <= w_beat + 1'b1;
            if (axi_wlast) begin
                axi_bvalid <= 1'b1;
            end
        end else begin
            axi_wready <= 1'($urandom_range(0, 1));
        end
    end

    // Refills ask for one aligned line of incrementing 8-byte beats
    read_burst_form: assert property (@(posedge clock) disable iff (reset)
        axi_arvalid && axi_arready |-> axi_arlen == 8'(line_words - 1)
            && axi_arsize == beat_size && axi_arburst == burst_incr
            && (axi_araddr & addr_t'(line_words * 8 - 1)) == '0)
        else begin
            $display("Read burst is not one aligned line of incrementing 8-byte beats");
            errors++;
        end

    write_burst_len: assert property (@(posedge clock) disable iff (reset)
        axi_awvalid && axi_awready |-> axi_awlen == 8'(line_words - 1))
        else begin
            $display("Write burst announced with a length other than one line");
            errors++;
        end

    write_burst_form: assert property (@(posedge clock) disable iff (reset)
        axi_awvalid && axi_awready |-> axi_awsize == beat_size && axi_awburst == burst_incr
            && (axi_awaddr & addr_t'(line_words * 8 - 1)) == '0)
        else begin
            $display("Write burst is not line aligned or not of incrementing 8-byte beats");
            errors++;
        end

    // wlast exactly on beat line_words and never earlier
    write_beat_count: assert property (@(posedge clock) disable iff (reset)
        axi_wvalid && axi_wready |-> axi_wlast == (w_beat == 9'(line_words - 1)))
        else begin
            $display("Write burst has wlast on beat %0d", $sampled(w_beat) + 1);
            errors++;
        end

endmodule

/* tb_dcache.sv */
`timescale 1ns/10ps

module tb_dcache import cache_pkg::*; ();

    localparam int num_requests = 34;
    localparam int cycle_limit  = 40 * num_requests * default_line_words;

    logic clock;
    logic reset;
    logic req_valid, req_write, req_ready;
    addr_t req_addr;
    word_t req_wdata;
    strb_t req_wstrb;
    logic rsp_valid, rsp_ready;
    word_t rsp_rdata;
    logic axi_arvalid, axi_arready, axi_rvalid, axi_rlast, axi_rready;
    addr_t axi_araddr;
    logic [7:0] axi_arlen;
    logic [2:0] axi_arsize;
    logic [1:0] axi_arburst;
    word_t axi_rdata;
    logic axi_awvalid, axi_awready, axi_wvalid, axi_wlast, axi_wready;
    addr_t axi_awaddr;
    logic [7:0] axi_awlen;
    logic [2:0] axi_awsize;
    logic [1:0] axi_awburst;
    word_t axi_wdata;
    strb_t axi_wstrb;
    logic axi_bvalid, axi_bready;
    logic [1:0] axi_bresp;

    word_t shadow [addr_t]; // Words written by the core so far
    word_t exp_data;
    logic  expect_hit;
    logic  random_ready;
    string test_name;
    int    errors;
    int    mem_errors;
    int    errors_before;
    int    test_count;
    int    requests;
    int    responses;
    int    cycles;

    dcache_top u_dut (.*);

    tb_axi_mem #(.line_words(default_line_words)) u_mem (.*, .errors(mem_errors));

    always #10 clock = ~clock;

    always @(posedge clock) begin
        rsp_ready <= random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    always @(posedge clock) begin
        if (!reset) begin
            requests  <= requests + (req_valid && req_ready);
            responses <= responses + (rsp_valid && rsp_ready);
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic word_t expected_word(addr_t a);
        return shadow.exists(a) ? shadow[a] : {a ^ 32'h5A5A_0000, a ^ 32'h5A5A_0000};
    endfunction

    // One request through to its response; the shadow memory is updated first
    task automatic send_request(input logic write, input addr_t addr, input word_t data,
                                input strb_t strb, input logic hit);
        word_t w;
        w = expected_word(addr);
        if (write) begin
            for (int b = 0; b < strb_width; b++) begin
                if (strb[b]) begin
                    w[8*b +: 8] = data[8*b +: 8];
                end
            end
            shadow[addr] = w;
        end
        req_valid  <= 1'b1;
        req_write  <= write;
        req_addr   <= addr;
        req_wdata  <= data;
        req_wstrb  <= strb;
        exp_data   <= w;
        expect_hit <= hit;
        do @(posedge clock); while (!(req_valid && req_ready));
        req_valid  <= 1'b0;
        expect_hit <= 1'b0;
        do @(posedge clock); while (!(rsp_valid && rsp_ready));
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errors_before = errors + mem_errors;
    endtask

    task automatic end_test();
        repeat (2) @(posedge clock); // Let checks of the last edge report
        test_count++;
        $display("%s finished with %0d errors", test_name, errors + mem_errors - errors_before);
    endtask

    reset_outputs: assert property (@(posedge clock)
        $fell(reset) |-> req_ready && !rsp_valid && !axi_arvalid && !axi_rready
                         && !axi_awvalid && !axi_wvalid && !axi_bready)
        else begin
            $display("Control outputs not in their idle state after reset");
            errors++;
        end

    rsp_data_check: assert property (@(posedge clock) disable iff (reset)
        rsp_valid && rsp_ready |-> rsp_rdata == exp_data)
        else begin
            $display("ERR %s expected %h actual %h", test_name, $sampled(exp_data),
                     $sampled(rsp_rdata));
            errors++;
        end

    rsp_hold_check: assert property (@(posedge clock) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
        else begin
            $display("Response in %s dropped or changed before it was taken", test_name);
            errors++;
        end

    hit_latency_check: assert property (@(posedge clock) disable iff (reset)
        req_valid && req_ready && expect_hit |-> ##1 !rsp_valid ##1 rsp_valid)
        else begin
            $display("Hit response in %s not exactly 2 cycles after the request", test_name);
            errors++;
        end

    single_response: assert property (@(posedge clock) disable iff (reset)
        rsp_valid && rsp_ready |-> requests - responses == 1)
        else begin
            $display("Response in %s without a matching open request", test_name);
            errors++;
        end

    initial begin
        addr_t addr;
        void'($urandom(32'h4074));
        clock = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_wstrb = '0;
        rsp_ready = 1'b0;
        random_ready = 1'b0;
        expect_hit = 1'b0;
        exp_data = '0;
        errors = 0;
        test_count = 0;
        requests = 0;
        responses = 0;
        cycles = 0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        begin_test("reset_state");
        end_test();

        begin_test("read_miss_then_hit");
        send_request(1'b0, 32'h100, '0, '0, 1'b0);
        send_request(1'b0, 32'h108, '0, '0, 1'b1);
        end_test();

        begin_test("partial_write");
        send_request(1'b1, 32'h110, 64'h1122_3344_5566_7788, 8'b0011_1100, 1'b1);
        send_request(1'b0, 32'h110, '0, '0, 1'b1);
        end_test();

        // Three lines of set 1 with two ways so the third write evicts a dirty line
        begin_test("dirty_eviction");
        for (int i = 0; i < 3; i++) begin
            send_request(1'b1, 32'h058 + 32'h100 * i, {$urandom, $urandom}, '1, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            send_request(1'b0, 32'h058 + 32'h100 * i, '0, '0, 1'b0);
        end
        end_test();

        begin_test("random_backpressure");
        random_ready <= 1'b1;
        repeat (24) begin
            addr = addr_t'($urandom_range(0, 127)) << 3; // 16 lines over all sets
            if ($urandom_range(0, 1) == 1) begin
                send_request(1'b1, addr, {$urandom, $urandom}, strb_t'($urandom), 1'b0);
            end else begin
                send_request(1'b0, addr, '0, '0, 1'b0);
            end
        end
        random_ready <= 1'b0;
        end_test();

        count_check: assert (requests == num_requests && responses == requests)
        else begin
            $display("Request count %0d and response count %0d do not match",
                     requests, responses);
            errors++;
        end

        $display("Summary: %0d tests, %0d requests, %0d responses, %0d errors",
                 test_count, requests, responses, errors + mem_errors);
        if (errors + mem_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
